//--- source/periph_defs.svh
// Fabric constants; offsets assume 64-byte word slots and 16-byte byte slots, all pins reset to GPIO
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32
`define PERIPH_PINS 8

// Slot numbers of the populated peripherals
`define PERIPH_SLOT_GPIO 1
`define PERIPH_SLOT_WORD_EX 15
`define PERIPH_SLOT_BYTE_EX 15

// Every output pin comes out of reset on the GPIO slot, word bank
`define PERIPH_SEL_RESET 5'd1

// GPIO register map, pin selects one per word from the base
`define PERIPH_GPIO_OUT_OFS 6'h00
`define PERIPH_GPIO_IN_OFS 6'h04
`define PERIPH_GPIO_SEL_OFS 6'h20

// Word example interrupt clear
`define PERIPH_WEX_CLR_OFS 6'h08

`endif

//--- source/periph_pkg.sv
// Shared fabric types; size codes follow the core encoding, 11 meaning no access
`include "periph_defs.svh"

package periph_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] word_t;
    typedef logic [7:0]                byte_t;
    typedef logic [`PERIPH_PINS-1:0]   pins_t;
    typedef logic [3:0]                slot_t;
    typedef logic [4:0]                pin_sel_t;  // [4] byte bank, [3:0] slot

    // Access size as driven by the core
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10,
        size_none = 2'b11
    } xfer_size_e;

    // Request into a word-interface slot
    typedef struct packed {
        logic [5:0] ofs;
        word_t      wdata;
        xfer_size_e write_n;
        xfer_size_e read_n;
    } word_req_s;

    // Request into a byte-interface slot
    typedef struct packed {
        logic [3:0] ofs;
        logic       wr;
        byte_t      wdata;
    } byte_req_s;

    typedef struct packed {
        word_t rdata;
        logic  ready;
    } word_rsp_s;

endpackage

//--- source/periph_addr_decode.sv
// Address decode stage; bit 10 picks the byte bank, unselected slots always see no access
`include "periph_defs.svh"

module periph_addr_decode (
    input  periph_pkg::addr_t      i_addr,
    input  periph_pkg::word_t      i_wdata,
    input  periph_pkg::xfer_size_e i_write_n,
    input  periph_pkg::xfer_size_e i_read_n,
    input  logic                   i_ready_held,
    output periph_pkg::word_req_s  o_gpio_req,
    output periph_pkg::word_req_s  o_wex_req,
    output periph_pkg::byte_req_s  o_bex_req,
    output logic                   o_byte_bank,
    output periph_pkg::slot_t      o_slot
);

    periph_pkg::xfer_size_e read_n_masked;
    logic                   gpio_sel;
    logic                   wex_sel;
    logic                   bex_sel;

    // No new read reaches a slot while the last result is still on offer
    assign read_n_masked = i_ready_held ? periph_pkg::size_none : i_read_n;

    assign o_byte_bank = i_addr[10];
    assign o_slot      = o_byte_bank ? i_addr[7:4] : i_addr[9:6];

    assign gpio_sel = !o_byte_bank && (o_slot == periph_pkg::slot_t'(`PERIPH_SLOT_GPIO));
    assign wex_sel  = !o_byte_bank && (o_slot == periph_pkg::slot_t'(`PERIPH_SLOT_WORD_EX));
    assign bex_sel  = o_byte_bank && (o_slot == periph_pkg::slot_t'(`PERIPH_SLOT_BYTE_EX));

    always_comb begin
        o_gpio_req.ofs     = i_addr[5:0];
        o_gpio_req.wdata   = i_wdata;
        o_gpio_req.write_n = gpio_sel ? i_write_n : periph_pkg::size_none;
        o_gpio_req.read_n  = gpio_sel ? read_n_masked : periph_pkg::size_none;

        o_wex_req.ofs      = i_addr[5:0];
        o_wex_req.wdata    = i_wdata;
        o_wex_req.write_n  = wex_sel ? i_write_n : periph_pkg::size_none;
        o_wex_req.read_n   = wex_sel ? read_n_masked : periph_pkg::size_none;

        // Byte slots only see a write strobe, reads are purely combinational
        o_bex_req.ofs      = i_addr[3:0];
        o_bex_req.wdata    = i_wdata[7:0];
        o_bex_req.wr       = bex_sel && (i_write_n != periph_pkg::size_none);
    end

endmodule

//--- source/periph_gpio.sv
// GPIO slot; any write size updates a register and pins from unpopulated slots drive zero
`include "periph_defs.svh"

module periph_gpio (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::word_req_s i_req,
    input  periph_pkg::pins_t     i_ui_in,
    input  periph_pkg::pins_t     i_wex_pins,
    input  periph_pkg::pins_t     i_bex_pins,
    output periph_pkg::word_rsp_s o_rsp,
    output periph_pkg::pins_t     o_uo_out
);

    localparam int IDX_W = $clog2(`PERIPH_PINS);

    periph_pkg::pins_t    gpio_out;
    periph_pkg::pin_sel_t pin_sel [`PERIPH_PINS];
    logic [5:0]           sel_rel;
    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_hit;
    logic                 wr_en;

    assign wr_en   = i_req.write_n != periph_pkg::size_none;
    assign sel_rel = i_req.ofs - `PERIPH_GPIO_SEL_OFS;
    assign sel_idx = sel_rel[IDX_W+1:2];
    assign sel_hit = (i_req.ofs >= `PERIPH_GPIO_SEL_OFS) && (i_req.ofs[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && i_req.ofs == `PERIPH_GPIO_OUT_OFS) begin
            gpio_out <= i_req.wdata[`PERIPH_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERIPH_PINS; i++) begin
                pin_sel[i] <= `PERIPH_SEL_RESET;
            end
        end else if (wr_en && sel_hit) begin
            pin_sel[sel_idx] <= i_req.wdata[4:0];  // One select per word
        end
    end

    // Register read-back is answered in the same cycle
    always_comb begin
        if (i_req.ofs == `PERIPH_GPIO_OUT_OFS) begin
            o_rsp.rdata = periph_pkg::word_t'(gpio_out);
        end else if (i_req.ofs == `PERIPH_GPIO_IN_OFS) begin
            o_rsp.rdata = periph_pkg::word_t'(i_ui_in);
        end else if (sel_hit) begin
            o_rsp.rdata = periph_pkg::word_t'(pin_sel[sel_idx]);
        end else begin
            o_rsp.rdata = '0;
        end
        o_rsp.ready = i_req.read_n != periph_pkg::size_none;
    end

    // Per-pin output function mux
    always_comb begin
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            o_uo_out[i] = 1'b0;
            if (pin_sel[i][4]) begin
                if (pin_sel[i][3:0] == periph_pkg::slot_t'(`PERIPH_SLOT_BYTE_EX))
                    o_uo_out[i] = i_bex_pins[i];
            end else if (pin_sel[i][3:0] == periph_pkg::slot_t'(`PERIPH_SLOT_GPIO)) begin
                o_uo_out[i] = gpio_out[i];
            end else if (pin_sel[i][3:0] == periph_pkg::slot_t'(`PERIPH_SLOT_WORD_EX)) begin
                o_uo_out[i] = i_wex_pins[i];  // Word example low byte
            end
        end
    end

endmodule

//--- source/periph_word_example.sv
// Word slot example; one register at offset 0, read ready lags the request by one cycle
`include "periph_defs.svh"

module periph_word_example (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::word_req_s i_req,
    output periph_pkg::word_rsp_s o_rsp,
    output periph_pkg::pins_t     o_pins,
    output logic                  o_interrupt
);

    periph_pkg::word_t data_q;
    logic              rd_ready_q;
    logic              irq_q;
    logic              wr_reg;

    assign wr_reg = (i_req.write_n != periph_pkg::size_none) && (i_req.ofs == 6'h00);

    // Sized write keeps the untouched upper bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (wr_reg) begin
            case (i_req.write_n)
                periph_pkg::size_byte: data_q[7:0]  <= i_req.wdata[7:0];
                periph_pkg::size_half: data_q[15:0] <= i_req.wdata[15:0];
                default:               data_q       <= i_req.wdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q      <= 1'b0;
            rd_ready_q <= 1'b0;
        end else begin
            if (wr_reg) begin
                irq_q <= 1'b1;
            end else if (i_req.write_n != periph_pkg::size_none &&
                         i_req.ofs == `PERIPH_WEX_CLR_OFS) begin
                irq_q <= 1'b0;
            end
            rd_ready_q <= i_req.read_n != periph_pkg::size_none;  // Deliberately slow
        end
    end

    assign o_rsp.rdata = (i_req.ofs == 6'h00) ? data_q : '0;
    assign o_rsp.ready = rd_ready_q;
    assign o_pins      = data_q[`PERIPH_PINS-1:0];
    assign o_interrupt = irq_q;

endmodule

//--- source/periph_byte_example.sv
// Byte slot example; two registers at offsets 0 and 1, everything else reads zero
module periph_byte_example (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::byte_req_s i_req,
    output periph_pkg::byte_t     o_rdata,
    output periph_pkg::pins_t     o_pins
);

    periph_pkg::byte_t reg0_q;
    periph_pkg::byte_t reg1_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg0_q <= '0;
            reg1_q <= '0;
        end else if (i_req.wr) begin
            case (i_req.ofs)
                4'h0:    reg0_q <= i_req.wdata;
                4'h1:    reg1_q <= i_req.wdata;
                default: ;  // Writes elsewhere are dropped
            endcase
        end
    end

    always_comb begin
        case (i_req.ofs)
            4'h0:    o_rdata = reg0_q;
            4'h1:    o_rdata = reg1_q;
            default: o_rdata = '0;
        endcase
    end

    // Pins mirror register 0
    assign o_pins = reg0_q;

endmodule

//--- source/periph_read_response.sv
// Read response stage; result is held until the core signals completion, writes ack at once
`include "periph_defs.svh"

module periph_read_response (
    input  logic                   clk,
    input  logic                   rst_n,
    input  periph_pkg::xfer_size_e i_read_n,
    input  periph_pkg::xfer_size_e i_write_n,
    input  logic                   i_read_complete,
    input  logic                   i_byte_bank,
    input  periph_pkg::slot_t      i_slot,
    input  periph_pkg::word_rsp_s  i_gpio_rsp,
    input  periph_pkg::word_rsp_s  i_wex_rsp,
    input  periph_pkg::byte_t      i_bex_rdata,
    output periph_pkg::word_t      o_rdata,
    output logic                   o_data_ready,
    output logic                   o_ready_held
);

    periph_pkg::word_rsp_s sel_rsp;
    periph_pkg::word_t     rdata_q;
    logic                  hold_q;
    logic                  ready_q;
    logic                  read_req;

    assign read_req = i_read_n != periph_pkg::size_none;

    // Empty slots answer zero straight away
    always_comb begin
        sel_rsp = '{rdata: '0, ready: 1'b1};
        if (i_byte_bank) begin
            if (i_slot == periph_pkg::slot_t'(`PERIPH_SLOT_BYTE_EX))
                sel_rsp.rdata = periph_pkg::word_t'(i_bex_rdata);
        end else if (i_slot == periph_pkg::slot_t'(`PERIPH_SLOT_GPIO)) begin
            sel_rsp = i_gpio_rsp;
        end else if (i_slot == periph_pkg::slot_t'(`PERIPH_SLOT_WORD_EX)) begin
            sel_rsp = i_wex_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (!hold_q && sel_rsp.ready && read_req) begin
                hold_q <= 1'b1;
            end else if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            ready_q <= read_req && (hold_q || sel_rsp.ready);  // Stays up while held
        end
    end

    // Capture once, keep until released
    always_ff @(posedge clk) begin
        if (!hold_q && sel_rsp.ready && read_req)
            rdata_q <= sel_rsp.rdata;
    end

    assign o_rdata      = rdata_q;
    assign o_ready_held = ready_q;
    assign o_data_ready = ready_q || (i_write_n != periph_pkg::size_none);

endmodule

//--- source/periph_fabric.sv
// Peripheral fabric top; only GPIO, word slot 15 and byte slot 15 are populated
module periph_fabric (
    input  logic                   clk,
    input  logic                   rst_n,
    input  periph_pkg::pins_t      i_ui_in,
    input  periph_pkg::addr_t      i_addr,
    input  periph_pkg::word_t      i_wdata,
    input  periph_pkg::xfer_size_e i_write_n,
    input  periph_pkg::xfer_size_e i_read_n,
    input  logic                   i_read_complete,
    output periph_pkg::pins_t      o_uo_out,
    output periph_pkg::word_t      o_rdata,
    output logic                   o_data_ready,
    output logic                   o_interrupt
);

    periph_pkg::word_req_s gpio_req;
    periph_pkg::word_req_s wex_req;
    periph_pkg::byte_req_s bex_req;
    periph_pkg::word_rsp_s gpio_rsp;
    periph_pkg::word_rsp_s wex_rsp;
    periph_pkg::byte_t     bex_rdata;
    periph_pkg::pins_t     wex_pins;
    periph_pkg::pins_t     bex_pins;
    periph_pkg::slot_t     slot;
    logic                  byte_bank;
    logic                  ready_held;

    // Stage 1, decode
    periph_addr_decode periph_addr_decode_i (
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_write_n    (i_write_n),
        .i_read_n     (i_read_n),
        .i_ready_held (ready_held),
        .o_gpio_req   (gpio_req),
        .o_wex_req    (wex_req),
        .o_bex_req    (bex_req),
        .o_byte_bank  (byte_bank),
        .o_slot       (slot)
    );

    // Stage 2, slots
    periph_gpio periph_gpio_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (gpio_req),
        .i_ui_in    (i_ui_in),
        .i_wex_pins (wex_pins),
        .i_bex_pins (bex_pins),
        .o_rsp      (gpio_rsp),
        .o_uo_out   (o_uo_out)
    );

    periph_word_example periph_word_example_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (wex_req),
        .o_rsp       (wex_rsp),
        .o_pins      (wex_pins),
        .o_interrupt (o_interrupt)
    );

    periph_byte_example periph_byte_example_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (bex_req),
        .o_rdata (bex_rdata),
        .o_pins  (bex_pins)
    );

    // Stage 3, read response
    periph_read_response periph_read_response_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_byte_bank     (byte_bank),
        .i_slot          (slot),
        .i_gpio_rsp      (gpio_rsp),
        .i_wex_rsp       (wex_rsp),
        .i_bex_rdata     (bex_rdata),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready),
        .o_ready_held    (ready_held)
    );

endmodule

//--- sim/periph_fabric_tb.sv
// Table addresses assume 64-byte word slots from 0x000 and 16-byte byte slots from 0x400
module periph_fabric_tb;

    localparam int CLK_PERIOD       = 4;
    localparam int RESET_CYCLES     = 10;
    localparam int NUM_ENTRIES      = 35;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam int READ_WAIT_MAX    = 8;
    localparam periph_pkg::addr_t      WEX_ADDR = 11'h3C0;  // Word slot 15 at offset 0
    localparam periph_pkg::xfer_size_e SZ_B     = periph_pkg::size_byte;
    localparam periph_pkg::xfer_size_e SZ_H     = periph_pkg::size_half;
    localparam periph_pkg::xfer_size_e SZ_W     = periph_pkg::size_word;
    localparam periph_pkg::xfer_size_e SZ_N     = periph_pkg::size_none;

    typedef enum logic [1:0] {op_write, op_read, op_pins, op_irq} op_e;
    typedef enum logic [1:0] {val_fixed, val_random, val_model} val_e;

    // One step of the test table
    typedef struct packed {
        op_e                    op;
        periph_pkg::xfer_size_e size;
        periph_pkg::addr_t      addr;
        periph_pkg::word_t      data;
        periph_pkg::pins_t      ui;
        periph_pkg::word_t      exp;
        val_e                   src;  // Random write data or model-based expectation
    } entry_s;

    logic                   clk;
    logic                   rst_n;
    periph_pkg::pins_t      ui_in;
    periph_pkg::addr_t      addr;
    periph_pkg::word_t      wdata;
    periph_pkg::xfer_size_e write_n;
    periph_pkg::xfer_size_e read_n;
    logic                   read_complete;
    periph_pkg::pins_t      uo_out;
    periph_pkg::word_t      rdata;
    logic                   data_ready;
    logic                   irq;

    entry_s            entries [NUM_ENTRIES];
    int                n_entries;
    logic [15:0]       lfsr_q;
    periph_pkg::word_t wex_model;  // Expected word example register

    periph_fabric periph_fabric_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_wdata         (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_uo_out        (uo_out),
        .o_rdata         (rdata),
        .o_data_ready    (data_ready),
        .o_interrupt     (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY) * CLK_PERIOD);
        $display("Watchdog expired, the run hung");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    task automatic check_value(input periph_pkg::word_t got, input periph_pkg::word_t exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output periph_pkg::word_t v);
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    // Word example answers one cycle later than every other slot
    function automatic int read_latency(input periph_pkg::addr_t a);
        return (!a[10] && a[9:6] == 4'd15) ? 2 : 1;
    endfunction

    task automatic add_entry(input op_e op, input periph_pkg::xfer_size_e size,
                             input periph_pkg::addr_t a, input periph_pkg::word_t d,
                             input periph_pkg::pins_t ui, input periph_pkg::word_t exp,
                             input val_e src);
        entries[n_entries] = '{op, size, a, d, ui, exp, src};
        n_entries++;
    endtask

    task automatic load_table();
        add_entry(op_write, SZ_W, 11'h040, 32'h0000_00A5, 8'h00, 32'h0, val_fixed);
        add_entry(op_pins,  SZ_N, 11'h000, 32'h0, 8'h00, 32'h0000_00A5, val_fixed);
        add_entry(op_read,  SZ_W, 11'h040, 32'h0, 8'h00, 32'h0000_00A5, val_fixed);
        add_entry(op_read,  SZ_W, 11'h044, 32'h0, 8'h3C, 32'h0000_003C, val_fixed);
        add_entry(op_irq,   SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0, val_fixed);
        // Sized writes into the word example
        add_entry(op_write, SZ_W, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_random);
        add_entry(op_irq,   SZ_N, 11'h000, 32'h0, 8'h3C, 32'h1, val_fixed);
        add_entry(op_read,  SZ_W, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_model);
        add_entry(op_write, SZ_B, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_random);
        add_entry(op_read,  SZ_W, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_model);
        add_entry(op_write, SZ_H, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_random);
        add_entry(op_read,  SZ_W, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_model);
        add_entry(op_write, SZ_W, 11'h3C8, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_irq,   SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_W, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_model);
        add_entry(op_write, SZ_W, 11'h3C0, 32'h0000_0008, 8'h3C, 32'h0, val_fixed);
        add_entry(op_irq,   SZ_N, 11'h000, 32'h0, 8'h3C, 32'h1, val_fixed);
        add_entry(op_write, SZ_B, 11'h4F0, 32'h0000_0020, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_B, 11'h4F0, 32'h0, 8'h3C, 32'h0000_0020, val_fixed);
        add_entry(op_write, SZ_B, 11'h4F1, 32'h0000_005A, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_B, 11'h4F1, 32'h0, 8'h3C, 32'h0000_005A, val_fixed);
        // Route pin 3 to the word example and pin 5 to the byte example
        add_entry(op_write, SZ_W, 11'h040, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_pins,  SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_write, SZ_W, 11'h06C, 32'd15, 8'h3C, 32'h0, val_fixed);
        add_entry(op_write, SZ_W, 11'h074, 32'd31, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_W, 11'h06C, 32'h0, 8'h3C, 32'd15, val_fixed);
        add_entry(op_read,  SZ_W, 11'h074, 32'h0, 8'h3C, 32'd31, val_fixed);
        add_entry(op_pins,  SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0000_0028, val_fixed);
        add_entry(op_write, SZ_B, 11'h3C0, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_pins,  SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0000_0020, val_fixed);
        add_entry(op_write, SZ_W, 11'h3C8, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_irq,   SZ_N, 11'h000, 32'h0, 8'h3C, 32'h0, val_fixed);
        // Empty word slot 3 and byte slot 2
        add_entry(op_read,  SZ_W, 11'h0C0, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_B, 11'h420, 32'h0, 8'h3C, 32'h0, val_fixed);
        add_entry(op_read,  SZ_W, 11'h040, 32'h0, 8'h3C, 32'h0, val_fixed);
    endtask

    task automatic write_access(input entry_s e);
        periph_pkg::word_t wr_data;
        wr_data = e.data;
        if (e.src == val_random)
            random_word(wr_data);
        if (e.addr == WEX_ADDR) begin
            case (e.size)
                periph_pkg::size_byte: wex_model[7:0]  = wr_data[7:0];
                periph_pkg::size_half: wex_model[15:0] = wr_data[15:0];
                default:               wex_model       = wr_data;
            endcase
        end
        @(posedge clk);
        #1;
        addr    = e.addr;
        wdata   = wr_data;
        ui_in   = e.ui;
        write_n = e.size;
        @(negedge clk);
        check_value(periph_pkg::word_t'(data_ready), 32'h1, "write acknowledge");
        @(posedge clk);
        #1;
        write_n = periph_pkg::size_none;
    endtask

    task automatic read_access(input entry_s e);
        int                cycles;
        periph_pkg::word_t exp_data;
        exp_data = (e.src == val_model) ? wex_model : e.exp;
        @(posedge clk);
        #1;
        addr   = e.addr;
        ui_in  = e.ui;
        read_n = e.size;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!data_ready && cycles < READ_WAIT_MAX);
        if (!data_ready) begin
            $display("Read of address 0x%03h never got data ready", e.addr);
            $display("Errors found");
            $fatal(1, "no data ready");
        end
        check_value(periph_pkg::word_t'(cycles), periph_pkg::word_t'(read_latency(e.addr)),
                    "read latency in cycles");
        check_value(rdata, exp_data, "read data");
        repeat (2) @(negedge clk);  // Result must sit still until completion
        check_value(periph_pkg::word_t'(data_ready), 32'h1, "held data ready");
        check_value(rdata, exp_data, "held read data");
        @(posedge clk);
        #1;
        read_complete = 1'b1;
        read_n        = periph_pkg::size_none;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
        @(negedge clk);
        check_value(periph_pkg::word_t'(data_ready), 32'h0, "data ready after completion");
    endtask

    task automatic sample_outputs(input entry_s e);
        @(posedge clk);
        #1;
        ui_in = e.ui;
        @(negedge clk);
        if (e.op == op_pins)
            check_value(periph_pkg::word_t'(uo_out), e.exp, "output pins");
        else
            check_value(periph_pkg::word_t'(irq), e.exp, "interrupt");
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = periph_pkg::size_none;
        read_n        = periph_pkg::size_none;
        read_complete = 1'b0;
        lfsr_q        = 16'd44;
        wex_model     = '0;
        n_entries     = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(periph_pkg::word_t'(data_ready), 32'h0, "data ready after reset");
        check_value(periph_pkg::word_t'(irq), 32'h0, "interrupt after reset");
        check_value(periph_pkg::word_t'(uo_out), 32'h0, "output pins after reset");
        for (int i = 0; i < n_entries; i++) begin
            case (entries[i].op)
                op_write: write_access(entries[i]);
                op_read:  read_access(entries[i]);
                default:  sample_outputs(entries[i]);
            endcase
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- periph_fabric.f
+incdir+source
source/periph_pkg.sv
source/periph_addr_decode.sv
source/periph_gpio.sv
source/periph_word_example.sv
source/periph_byte_example.sv
source/periph_read_response.sv
source/periph_fabric.sv
sim/periph_fabric_tb.sv

//--- Makefile
# Verilator flow for the peripheral fabric
TB  = periph_fabric_tb
RTL = periph_fabric

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f periph_fabric.f --top-module $(RTL)
	verilator --lint-only --timing -f periph_fabric.f --top-module $(TB)

sim:
	verilator --binary --timing -j 0 -f periph_fabric.f --top-module $(TB) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
